//--- uartPkg.sv
package uartPkg;

	//////////////////////////////
	// widths with a meaning
	//////////////////////////////

	typedef logic [7:0] dataByte;		// one character, line or cpu side
	typedef logic [3:0] fifoPtr;		// read / write index, 16 entries
	typedef logic [4:0] fifoCount;		// fill level 0..16
	typedef logic [3:0] tickCount;		// oversampling count within a bit
	typedef logic [2:0] bitIndex;		// data bit position in the frame
	typedef logic [7:0] statusWord;		// value on the stat port

	//////////////////////////////
	// frame shape
	//////////////////////////////

	localparam int SAMPLE_TICKS = 16;	// 16x oversampling
	localparam int DATA_BITS = 8;		// 8N1, no parity

	// same four phases on both sides of the line
	typedef enum logic [1:0] {
		idle  = 2'b00,
		start = 2'b01,
		data  = 2'b10,
		stop  = 2'b11
	} uartState;

	//////////////////////////////
	// status bit positions
	//////////////////////////////

	localparam int ST_TX_FULL = 0;
	localparam int ST_TX_EMPTY = 1;
	localparam int ST_TX_BUSY = 2;
	localparam int ST_RX_VALID = 3;
	localparam int ST_RX_OVERRUN = 4;
	localparam int ST_TX_OVERFLOW = 5;	// bits 6, 7 read zero

endpackage

//--- baudTickGen.sv
module baudTickGen #(
	parameter int clksPerTick = 4		// system clocks per 16x tick, 2 or more
) (
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	// wide enough to hold clksPerTick-1
	localparam int cntW = (clksPerTick > 2) ? $clog2(clksPerTick) : 1;
	localparam logic [cntW-1:0] reloadVal = cntW'(clksPerTick - 1);

	logic [cntW-1:0] cnt;	// cycles left to next tick

	// down-counter, tick leaves a flop so it cannot glitch
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt <= reloadVal;
			sTick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt <= reloadVal;	// wrap
			sTick <= 1'b1;
		end
		else
		begin
			cnt <= cnt - 1'b1;
			sTick <= 1'b0;
		end
	end

	// both fsms count one bit step per tick, a double tick would shorten the bit
	tickSingle: assert property (@(posedge clk) disable iff (reset)
		sTick |=> !sTick);

endmodule

//--- txFifo.sv
module txFifo (
	input  logic             clk,
	input  logic             reset,
	input  logic             wrStrobe,	// one-cycle cpu write
	input  uartPkg::dataByte wrData,
	input  logic             txPop,		// read pulse from transmitter
	output uartPkg::dataByte fifoData,	// head entry
	output logic             fifoEmpty,
	output logic             fifoFull,
	output logic             txOverflow	// sticky, write hit a full fifo
);

	localparam int depth = 2 ** $bits(uartPkg::fifoPtr);	// 16
	localparam uartPkg::fifoCount fullLevel = uartPkg::fifoCount'(depth);

	uartPkg::dataByte mem [depth];		// circular buffer
	uartPkg::fifoPtr wrPtr;
	uartPkg::fifoPtr rdPtr;
	uartPkg::fifoCount count;

	logic doWrite;	// write accepted this cycle

	// strobe cannot be refused, so a full fifo just drops it
	assign doWrite = wrStrobe && !fifoFull;

	assign fifoFull = (count == fullLevel);
	assign fifoEmpty = (count == '0);
	assign fifoData = mem[rdPtr];		// head, unqualified

	//////////////////////////////
	// storage
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (doWrite)
			mem[wrPtr] <= wrData;
	end

	//////////////////////////////
	// pointers, level, flag
	//////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			txOverflow <= 1'b0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;	// wraps at 16
			if (txPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doWrite, txPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// none, or write and pop together
			endcase
			if (wrStrobe && fifoFull)
				txOverflow <= 1'b1;		// held until reset
		end
	end

	// empty test lives in the transmitter, a pop here means it got it wrong
	popNotEmpty: assert property (@(posedge clk) disable iff (reset)
		txPop |-> !fifoEmpty);

	levelInRange: assert property (@(posedge clk) disable iff (reset)
		count <= fullLevel);

endmodule

//--- uartTrans.sv
module uartTrans (
	input  logic             clk,
	input  logic             reset,
	input  logic             sTick,		// 16x tick
	input  logic             fifoEmpty,
	input  uartPkg::dataByte fifoData,	// head of tx fifo
	output logic             txPop,		// fifo read, one cycle at frame start
	output logic             tx,		// serial out, idle high
	output logic             txBusy
);

	localparam uartPkg::tickCount lastTick = uartPkg::tickCount'(uartPkg::SAMPLE_TICKS - 1);
	localparam uartPkg::bitIndex lastBit = uartPkg::bitIndex'(uartPkg::DATA_BITS - 1);

	uartPkg::uartState stateReg, stateNext;
	uartPkg::tickCount sReg, sNext;		// ticks within current bit
	uartPkg::bitIndex nReg, nNext;		// data bits sent
	uartPkg::dataByte bReg, bNext;		// shift register, lsb goes out
	logic txReg, txNext;				// line level, registered

	//////////////////////////////
	// state registers
	//////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::idle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;		// mark
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	// payload only, loaded at start and shifted in data
	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		txPop = 1'b0;

		case (stateReg)
			uartPkg::idle:
			begin
				txNext = 1'b1;
				if (!fifoEmpty)
				begin
					txPop = 1'b1;			// fifo advances on this pulse
					bNext = fifoData;		// latch head before it moves
					txNext = 1'b0;			// start bit next cycle
					sNext = '0;
					stateNext = uartPkg::start;
				end
			end
			uartPkg::start:
			begin
				if (sTick)
				begin
					if (sReg == lastTick)
					begin
						sNext = '0;
						nNext = '0;
						txNext = bReg[0];	// first data bit
						stateNext = uartPkg::data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::data:
			begin
				if (sTick)
				begin
					if (sReg == lastTick)
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == lastBit)
						begin
							txNext = 1'b1;	// stop bit
							stateNext = uartPkg::stop;
						end
						else
						begin
							nNext = nReg + 1'b1;
							txNext = bReg[1];	// next bit after shift
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default:	// stop
			begin
				if (sTick)
				begin
					if (sReg == lastTick)
						stateNext = uartPkg::idle;	// last stop tick, ready for next
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	assign tx = txReg;
	assign txBusy = (stateReg != uartPkg::idle);

	popOnlyIdle: assert property (@(posedge clk) disable iff (reset)
		txPop |-> (stateReg == uartPkg::idle));

	// line must be at mark outside start and data
	markOutsideFrame: assert property (@(posedge clk) disable iff (reset)
		(stateReg == uartPkg::idle || stateReg == uartPkg::stop) |-> tx);

endmodule

//--- uartRecv.sv
module uartRecv (
	input  logic             clk,
	input  logic             reset,
	input  logic             sTick,		// 16x tick
	input  logic             rx,		// async serial in
	input  logic             rdStrobe,	// cpu read, clears valid
	output uartPkg::dataByte rxData,	// holding register
	output logic             rxValid,
	output logic             rxOverrun	// sticky
);

	localparam uartPkg::tickCount lastTick = uartPkg::tickCount'(uartPkg::SAMPLE_TICKS - 1);
	localparam uartPkg::tickCount midTick = uartPkg::tickCount'(uartPkg::SAMPLE_TICKS / 2 - 1);
	localparam uartPkg::bitIndex lastBit = uartPkg::bitIndex'(uartPkg::DATA_BITS - 1);

	logic rxMeta, rxSync;				// two-flop synchronizer

	uartPkg::uartState stateReg, stateNext;
	uartPkg::tickCount sReg, sNext;
	uartPkg::bitIndex nReg, nNext;
	uartPkg::dataByte bReg, bNext;		// shift in, lsb first
	uartPkg::dataByte rxHold;
	logic commit;						// byte complete, middle of stop bit

	//////////////////////////////
	// sync and state registers
	//////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;		// line idles high
			rxSync <= 1'b1;
			stateReg <= uartPkg::idle;
			sReg <= '0;
			nReg <= '0;
			rxValid <= 1'b0;
			rxOverrun <= 1'b0;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			if (commit)
			begin
				rxValid <= 1'b1;	// new byte wins over a read in the same cycle
				if (rxValid && !rdStrobe)
					rxOverrun <= 1'b1;	// old byte never read
			end
			else if (rdStrobe)
				rxValid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
		if (commit)
			rxHold <= bReg;		// stale byte simply overwritten
	end

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		commit = 1'b0;

		case (stateReg)
			uartPkg::idle:
			begin
				if (!rxSync)		// falling edge, maybe a start bit
				begin
					sNext = '0;
					stateNext = uartPkg::start;
				end
			end
			uartPkg::start:
			begin
				if (sTick)
				begin
					if (sReg == midTick)
					begin
						sNext = '0;
						nNext = '0;
						// still low at mid-bit, else a glitch
						stateNext = rxSync ? uartPkg::idle : uartPkg::data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::data:
			begin
				if (sTick)
				begin
					if (sReg == lastTick)
					begin
						sNext = '0;
						bNext = {rxSync, bReg[7:1]};	// sample mid-bit
						if (nReg == lastBit)
							stateNext = uartPkg::stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default:	// stop
			begin
				if (sTick)
				begin
					if (sReg == lastTick)
					begin
						commit = 1'b1;				// middle of stop bit
						stateNext = uartPkg::idle;	// rest of stop bit is mark
					end
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	assign rxData = rxHold;

	// valid only rises on the commit from stop
	validFromStop: assert property (@(posedge clk) disable iff (reset)
		(rxValid && !$past(rxValid)) |-> ($past(stateReg) == uartPkg::stop));

endmodule

//--- uartPeriph.sv
module uartPeriph #(
	parameter int clksPerTick = 4		// clocks per 16x tick
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               wrStrobe,	// cpu wr opcode
	input  uartPkg::dataByte   wrData,
	input  logic               rdStrobe,	// cpu rd opcode
	output uartPkg::dataByte   rdData,
	output uartPkg::statusWord status,		// cpu stat opcode
	output logic               tx,
	input  logic               rx
);

	logic sTick;
	logic txPop;
	logic fifoEmpty;
	logic fifoFull;
	logic txOverflow;
	logic txBusy;
	logic rxValid;
	logic rxOverrun;
	uartPkg::dataByte fifoData;

	//////////////////////////////
	// blocks
	//////////////////////////////

	baudTickGen #(
		.clksPerTick(clksPerTick)
	) tickGen (
		.clk  (clk),
		.reset(reset),
		.sTick(sTick)
	);

	txFifo fifo (
		.clk       (clk),
		.reset     (reset),
		.wrStrobe  (wrStrobe),
		.wrData    (wrData),
		.txPop     (txPop),
		.fifoData  (fifoData),
		.fifoEmpty (fifoEmpty),
		.fifoFull  (fifoFull),
		.txOverflow(txOverflow)
	);

	uartTrans trans (
		.clk      (clk),
		.reset    (reset),
		.sTick    (sTick),
		.fifoEmpty(fifoEmpty),
		.fifoData (fifoData),
		.txPop    (txPop),
		.tx       (tx),
		.txBusy   (txBusy)
	);

	uartRecv recv (
		.clk      (clk),
		.reset    (reset),
		.sTick    (sTick),		// same tick as transmitter
		.rx       (rx),
		.rdStrobe (rdStrobe),
		.rxData   (rdData),		// holding register straight out
		.rxValid  (rxValid),
		.rxOverrun(rxOverrun)
	);

	// status word, unused bits stay zero
	always_comb
	begin
		status = '0;
		status[uartPkg::ST_TX_FULL] = fifoFull;
		status[uartPkg::ST_TX_EMPTY] = fifoEmpty;
		status[uartPkg::ST_TX_BUSY] = txBusy;
		status[uartPkg::ST_RX_VALID] = rxValid;
		status[uartPkg::ST_RX_OVERRUN] = rxOverrun;
		status[uartPkg::ST_TX_OVERFLOW] = txOverflow;
	end

endmodule

//--- uartPeriphTb.sv
module uartPeriphTb;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int clksPerTick = 4;
	localparam int bitClks = uartPkg::SAMPLE_TICKS * clksPerTick;	// 64 clocks per bit
	localparam int bytesSent = 1 + 10 + 17 + 2;		// dropped bytes never reach the line
	localparam int watchdogCycles = bytesSent * 1700 + 2000;

	logic clk;
	logic reset;
	logic wrStrobe;
	uartPkg::dataByte wrData;
	logic rdStrobe;
	uartPkg::dataByte rdData;
	uartPkg::statusWord status;
	wire loop;		// tx back into rx

	uartPkg::dataByte expQ[$];	// bytes the line must deliver in order
	int modelCount;		// modeled fifo level
	bit modelOverflow;
	bit modelValid;
	bit modelOverrun;
	bit autoRead;		// checker reads every byte
	bit readReq;		// one read pulse wanted
	bit busyGap;
	int errorCount;
	int errStart;
	int testsRun;
	int testsFailed;

	uartPeriph #(.clksPerTick(clksPerTick)) DUT (
		.clk(clk), .reset(reset), .wrStrobe(wrStrobe), .wrData(wrData),
		.rdStrobe(rdStrobe), .rdData(rdData), .status(status), .tx(loop), .rx(loop)
	);

	always #50 clk = ~clk;

	//////////////////////////////
	// reference model
	//////////////////////////////

	// status on a quiet line with the transmitter idle
	function automatic uartPkg::statusWord expectStatus(input int count, input bit overflow,
			input bit valid, input bit overrun);
		uartPkg::statusWord s;
		s = '0;
		s[uartPkg::ST_TX_FULL] = (count == 16);
		s[uartPkg::ST_TX_EMPTY] = (count == 0);
		s[uartPkg::ST_RX_VALID] = valid;
		s[uartPkg::ST_RX_OVERRUN] = overrun;
		s[uartPkg::ST_TX_OVERFLOW] = overflow;
		return s;
	endfunction

	task automatic reportValue(input string sig, input logic [31:0] got,
			input logic [31:0] exp);
		$display("[ERROR] %s: got 0x%02h, expected 0x%02h", sig, got, exp);
		errorCount++;
	endtask

	task automatic checkStatus();
		uartPkg::statusWord exp;
		exp = expectStatus(modelCount, modelOverflow, modelValid, modelOverrun);
		assert (status === exp) else reportValue("status", 32'(status), 32'(exp));
	endtask

	// n random bytes on back-to-back cycles
	// model keeps only what fits
	task automatic writeBurst(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(negedge clk);
			wrData = uartPkg::dataByte'($urandom);
			wrStrobe = 1'b1;
			if (modelCount < 16)
			begin
				expQ.push_back(wrData);
				modelCount++;
			end
			else
				modelOverflow = 1'b1;	// write dropped and flag sticks
		end
		@(negedge clk);
		wrStrobe = 1'b0;
	endtask

	// wait for all but keep bytes with the fifo drained and the transmitter idle
	task automatic waitDrained(input int keep, input bit watchBusy);
		bit done;
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			if (watchBusy && expQ.size() > 0 && !status[uartPkg::ST_TX_BUSY]
					&& status[uartPkg::ST_TX_EMPTY])
				busyGap = 1'b1;		// nothing left to send yet bytes missing
			done = (expQ.size() <= keep) && !status[uartPkg::ST_TX_BUSY]
				&& status[uartPkg::ST_TX_EMPTY] && !rdStrobe && !readReq;
		end
	endtask

	task automatic startTest();
		errStart = errorCount;
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errorCount == errStart)
			$display("test %0d %s: ok", testsRun, name);
		else
		begin
			testsFailed++;
			$display("test %0d %s: FAILED, %0d errors", testsRun, name, errorCount - errStart);
		end
	endtask

	//////////////////////////////
	// line monitor and checker
	//////////////////////////////

	// each start bit means the transmitter just took the fifo head
	initial
	begin
		@(negedge reset);
		forever
		begin
			@(negedge loop);
			modelCount--;
			repeat (9 * bitClks + bitClks / 2) @(posedge clk);	// on to mid stop bit
		end
	end

	initial
	begin : rxCompare
		bit validPrev;
		validPrev = 1'b0;
		forever
		begin
			@(negedge clk);
			rdStrobe = 1'b0;
			if (status[uartPkg::ST_RX_VALID] && !validPrev)		// new byte landed
			begin
				assert (expQ.size() > 0) else
				begin
					$display("rxValid rose with no byte outstanding");
					errorCount++;
				end
				if (expQ.size() > 0)
				begin
					assert (rdData === expQ[0]) else
						reportValue("rdData", 32'(rdData), 32'(expQ[0]));
					void'(expQ.pop_front());
				end
				if (autoRead)
					rdStrobe = 1'b1;
			end
			if (readReq)
			begin
				rdStrobe = 1'b1;
				readReq = 1'b0;
			end
			validPrev = status[uartPkg::ST_RX_VALID];
		end
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout, run still going after %0d cycles", watchdogCycles);
		$display("Verification failed");
		$finish;
	end

	//////////////////////////////
	// tests
	//////////////////////////////

	initial
	begin
		void'($urandom(68954));
		clk = 1'b0;
		reset = 1'b1;
		wrStrobe = 1'b0;
		wrData = '0;
		rdStrobe = 1'b0;
		modelCount = 0;
		modelOverflow = 1'b0;
		modelValid = 1'b0;
		modelOverrun = 1'b0;
		autoRead = 1'b1;
		readReq = 1'b0;
		busyGap = 1'b0;
		errorCount = 0;
		testsRun = 0;
		testsFailed = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		startTest();
		@(negedge clk);
		assert (loop === 1'b1) else reportValue("tx", 32'(loop), 1);
		checkStatus();
		endTest("reset state");

		startTest();
		writeBurst(1);
		waitDrained(0, 1'b0);
		checkStatus();
		endTest("single byte");

		startTest();
		writeBurst(10);
		waitDrained(0, 1'b1);
		assert (!busyGap) else
		begin
			$display("transmitter went idle while bytes were still pending");
			errorCount++;
		end
		checkStatus();
		endTest("burst of 10");

		startTest();
		writeBurst(1);
		do
			@(negedge clk);
		while (!(status[uartPkg::ST_TX_BUSY] && status[uartPkg::ST_TX_EMPTY]));	// head taken
		writeBurst(20);		// 16 fit and 4 are dropped
		assert (status[uartPkg::ST_TX_FULL] === 1'b1) else
			reportValue("status[TX_FULL]", 32'(status[uartPkg::ST_TX_FULL]), 1);
		waitDrained(0, 1'b0);
		checkStatus();
		endTest("overflow");

		startTest();
		autoRead = 1'b0;
		writeBurst(2);
		waitDrained(1, 1'b0);	// second byte sits unread
		assert (rdData === expQ[0]) else reportValue("rdData", 32'(rdData), 32'(expQ[0]));
		modelValid = 1'b1;
		modelOverrun = 1'b1;
		checkStatus();
		void'(expQ.pop_front());
		readReq = 1'b1;
		do
			@(negedge clk);
		while (readReq || rdStrobe);
		modelValid = 1'b0;
		checkStatus();
		autoRead = 1'b1;
		endTest("overrun");

		startTest();
		@(negedge clk);
		checkStatus();
		endTest("quiet status");

		$display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- all.f
uartPkg.sv
baudTickGen.sv
txFifo.sv
uartTrans.sv
uartRecv.sv
uartPeriph.sv
uartPeriphTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = uartPeriphTb
FILELIST  = all.f
BUILDDIR  = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
